/* build.f */
exec_pkg.sv
alu_core.sv
alu_operand_select.sv
alu_fu.sv
cdb_arbiter.sv
alu_cluster.sv
tb_clock_gen.sv
tb_alu_cluster.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ALU cluster testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tb_alu_cluster_sim

verilator --binary --timing -f build.f --top-module tb_alu_cluster --Mdir obj_dir -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* tb_alu_cluster.sv */
`default_nettype none

module tb_alu_cluster import exec_pkg::*; ();

    localparam int ISSUES         = 32 + 32 + 12 + 24 + 600;  // Tests 2 to 6
    localparam int TIMEOUT_CYCLES = ISSUES * 4 + 200;
    localparam data_t RESULT_FILL = 32'hfacebeec;
    localparam data_t OPA_FILL    = 32'hdeadface;
    localparam data_t OPB_FILL    = 32'hfacefeed;

    logic              clock;
    logic              reset;
    logic        [1:0] issue_valid;
    data_t       [1:0] rs1_value;
    data_t       [1:0] rs2_value;
    data_t       [1:0] pc;
    data_t       [1:0] npc;
    data_t       [1:0] inst;
    alu_func_t   [1:0] alu_func;
    opa_select_t [1:0] opa_select;
    opb_select_t [1:0] opb_select;
    tag_t        [1:0] tag;
    br_mask_t    [1:0] b_mask;
    br_task_t          rem_br_task;
    br_mask_t          rem_b_id;
    logic        [1:0] alu_stall;
    logic              cdb_valid;
    data_t             cdb_result;
    tag_t              cdb_tag;
    br_mask_t          cdb_b_mask;

    logic [31:0] lfsr_state     = 32'd90254;
    logic [1:0]  model_valid    = '0;
    data_t       model_result [2];
    tag_t        model_tag [2];
    br_mask_t    model_mask [2];
    int          compare_errors = 0;
    int          flow_errors    = 0;
    int          cdb_count      = 0;
    int          test_cdb       = 0;
    int          test_errors    = 0;
    tag_t        first_tag;
    tag_t        held_tag;

    tb_clock_gen #(.PERIOD(8)) clock_source (.clock(clock));

    alu_cluster #(.NUM_FU(2)) UUT (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .pc          (pc),
        .npc         (npc),
        .inst        (inst),
        .alu_func    (alu_func),
        .opa_select  (opa_select),
        .opb_select  (opb_select),
        .tag         (tag),
        .b_mask      (b_mask),
        .rem_br_task (rem_br_task),
        .rem_b_id    (rem_b_id),
        .alu_stall   (alu_stall),
        .cdb_valid   (cdb_valid),
        .cdb_result  (cdb_result),
        .cdb_tag     (cdb_tag),
        .cdb_b_mask  (cdb_b_mask)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random bits and reference result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int k = 0; k < n; k++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic data_t expected_result(input data_t rs1, input data_t rs2,
                                              input data_t pc_v, input data_t npc_v,
                                              input data_t iw, input logic [3:0] func,
                                              input logic [1:0] asel, input logic [2:0] bsel);
        data_t              a;
        data_t              b;
        logic signed [31:0] ext;
        case (asel)
            2'd0:    a = rs1;
            2'd1:    a = npc_v;
            2'd2:    a = pc_v;
            2'd3:    a = '0;
            default: a = OPA_FILL;
        endcase
        b   = '0;
        ext = iw;
        case (bsel)
            3'd0: b = rs2;
            3'd1: b = ext >>> 20;
            3'd2: begin
                ext = {iw[31:25], iw[11:7], 20'b0};
                b   = ext >>> 20;
            end
            3'd3: begin
                b[12]   = iw[31];
                b[11]   = iw[7];
                b[10:5] = iw[30:25];
                b[4:1]  = iw[11:8];
                ext     = b << 19;                  // Sign bit of the B immediate to bit 31
                b       = ext >>> 19;
            end
            3'd4: b = iw & 32'hfffff000;
            3'd5: begin
                b[20]    = iw[31];
                b[19:12] = iw[19:12];
                b[11]    = iw[20];
                b[10:1]  = iw[30:21];
                ext      = b << 11;
                b        = ext >>> 11;
            end
            default: b = OPB_FILL;
        endcase
        case (func)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'd4:    return (a < b) ? 32'd1 : 32'd0;
            4'd5:    return a | b;
            4'd6:    return a ^ b;
            4'd7:    return a >> b[4:0];
            4'd8:    return a << b[4:0];
            4'd9:    return data_t'($signed(a) >>> b[4:0]);
            default: return RESULT_FILL;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input data_t got, input data_t want);
        $display("[FAIL] %s got %h expected %h at time %0t", name, got, want, $time);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard model and CDB comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clock) begin : model_update
        logic [1:0] stall_m;
        logic       load;
        logic       nv;
        br_mask_t   nm;
        if (reset) begin
            model_valid   = '0;
            model_mask[0] = '0;
            model_mask[1] = '0;
        end else begin
            stall_m = {model_valid[0] & model_valid[1], 1'b0};  // Unit 0 always wins
            for (int u = 0; u < 2; u++) begin
                load = issue_valid[u] && !stall_m[u];
                nv   = stall_m[u] ? model_valid[u] : load;
                nm   = load ? b_mask[u] : model_mask[u];
                if (load) begin
                    model_result[u] = expected_result(rs1_value[u], rs2_value[u], pc[u],
                                                      npc[u], inst[u], alu_func[u],
                                                      opa_select[u], opb_select[u]);
                    model_tag[u]    = tag[u];
                end
                if (nv && ((nm & rem_b_id) != '0)) begin
                    if (rem_br_task == BR_SQUASH) begin
                        nv = 1'b0;
                    end
                    if (rem_br_task == BR_CLEAR) begin
                        nm = nm & ~rem_b_id;
                    end
                end
                model_valid[u] = nv;
                model_mask[u]  = nm;
            end
        end
    end

    always @(negedge clock) begin : compare
        logic       any;
        int         g;
        logic [1:0] stall_e;
        if (!reset) begin
            any     = model_valid[0] | model_valid[1];
            g       = model_valid[0] ? 0 : 1;
            stall_e = {model_valid[0] & model_valid[1], 1'b0};
            if (cdb_valid !== any) begin
                compare_errors++;
                report_mismatch("cdb_valid", data_t'(cdb_valid), data_t'(any));
            end
            if (alu_stall !== stall_e) begin
                compare_errors++;
                report_mismatch("alu_stall", data_t'(alu_stall), data_t'(stall_e));
            end
            if (any && cdb_valid) begin
                cdb_count++;
                if (cdb_result !== model_result[g]) begin
                    compare_errors++;
                    report_mismatch("cdb_result", cdb_result, model_result[g]);
                end
                if (cdb_tag !== model_tag[g]) begin
                    compare_errors++;
                    report_mismatch("cdb_tag", data_t'(cdb_tag), data_t'(model_tag[g]));
                end
                if (cdb_b_mask !== model_mask[g]) begin
                    compare_errors++;
                    report_mismatch("cdb_b_mask", data_t'(cdb_b_mask), data_t'(model_mask[g]));
                end
            end
        end
    end

    initial begin : watchdog
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(posedge clock);
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_fields(input int u, input logic [3:0] func,
                                input logic [1:0] asel, input logic [2:0] bsel);
        issue_valid[u] <= 1'b1;
        rs1_value[u]   <= take_bits(32);
        rs2_value[u]   <= take_bits(32);
        pc[u]          <= take_bits(32);
        npc[u]         <= take_bits(32);
        inst[u]        <= take_bits(32);
        alu_func[u]    <= alu_func_t'(func);
        opa_select[u]  <= opa_select_t'(asel);
        opb_select[u]  <= opb_select_t'(bsel);
        tag[u]         <= tag_t'(take_bits(TAG_W));
        b_mask[u]      <= br_mask_t'(take_bits(BR_MASK_W));
    endtask

    task automatic random_issue(input int u);
        drive_fields(u, 4'(take_bits(4)), 2'(take_bits(2)), 3'(take_bits(3)));
    endtask

    task automatic drive_idle();
        issue_valid <= '0;
        rem_br_task <= BR_NONE;
        rem_b_id    <= '0;
    endtask

    task automatic wait_idle();
        @(negedge clock);
        while (cdb_valid) begin
            @(negedge clock);
        end
    endtask

    task automatic send_single(input int u, input logic [3:0] func,
                               input logic [1:0] asel, input logic [2:0] bsel);
        @(posedge clock);
        drive_fields(u, func, asel, bsel);
        @(posedge clock);
        issue_valid <= '0;
        @(negedge clock);
        if (cdb_valid !== 1'b1) begin
            flow_errors++;
            $display("Issue on unit %0d did not reach the CDB one cycle later", u);
        end
        while (cdb_valid) begin
            @(negedge clock);
        end
    endtask

    task automatic finish_test(input int number, input string name);
        @(posedge clock);                           // Lets the comparison settle first
        $display("test %0d %s: %0d CDB results, %0d errors", number, name,
                 cdb_count - test_cdb, compare_errors + flow_errors - test_errors);
        test_cdb    = cdb_count;
        test_errors = compare_errors + flow_errors;
    endtask

    initial begin
        reset       = 1'b1;
        issue_valid = '0;
        rs1_value   = '0;
        rs2_value   = '0;
        pc          = '0;
        npc         = '0;
        inst        = '0;
        alu_func    = {ALU_ADD, ALU_ADD};
        opa_select  = {OPA_IS_RS1, OPA_IS_RS1};
        opb_select  = {OPB_IS_RS2, OPB_IS_RS2};
        tag         = '0;
        b_mask      = '0;
        rem_br_task = BR_NONE;
        rem_b_id    = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        repeat (5) @(posedge clock);
        finish_test(1, "idle after reset");

        for (int u = 0; u < 2; u++) begin
            for (int f = 0; f < 16; f++) begin
                send_single(u, 4'(f), 2'd0, 3'd0);
            end
        end
        finish_test(2, "register operations");

        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 8; b++) begin
                send_single(b % 2, (b % 2 == 0) ? 4'd0 : 4'd6, 2'(a), 3'(b));
            end
        end
        finish_test(3, "operand selection");

        repeat (4) begin
            @(posedge clock);
            random_issue(0);
            random_issue(1);
            @(posedge clock);
            first_tag = tag[0];
            held_tag  = tag[1];
            issue_valid[0] <= 1'b0;
            random_issue(1);                        // Arrives while unit 1 is stalled
            @(negedge clock);
            if (alu_stall[1] !== 1'b1 || cdb_tag !== first_tag) begin
                flow_errors++;
                $display("Unit 0 did not broadcast first with unit 1 stalled");
            end
            @(posedge clock);
            issue_valid <= '0;
            @(negedge clock);
            if (cdb_valid !== 1'b1 || cdb_tag !== held_tag) begin
                flow_errors++;
                $display("Held result of unit 1 was not broadcast next");
            end
            @(negedge clock);
            if (cdb_valid !== 1'b0) begin
                flow_errors++;
                $display("A strobe sent to a stalled unit was not ignored");
            end
        end
        finish_test(4, "back-pressure");

        repeat (6) begin
            @(posedge clock);
            random_issue(0);
            random_issue(1);
            @(posedge clock);
            random_issue(0);
            issue_valid[1] <= 1'b0;
            rem_br_task    <= (take_bits(1) != 0) ? BR_SQUASH : BR_CLEAR;
            rem_b_id       <= br_mask_t'(1 << take_bits(2));
            @(posedge clock);
            random_issue(0);
            rem_br_task <= BR_NONE;
            rem_b_id    <= '0;
            @(posedge clock);
            drive_idle();
            wait_idle();
        end
        finish_test(5, "branch resolution");

        repeat (300) begin
            @(posedge clock);
            for (int u = 0; u < 2; u++) begin
                if (take_bits(1) != 0) begin
                    random_issue(u);
                end else begin
                    issue_valid[u] <= 1'b0;
                end
            end
            rem_br_task <= br_task_t'(2'(take_bits(2)));
            rem_b_id    <= br_mask_t'(1 << take_bits(2));
        end
        @(posedge clock);
        drive_idle();
        wait_idle();
        finish_test(6, "random mix");

        $display("summary: 6 tests, %0d CDB results, %0d errors", cdb_count,
                 compare_errors + flow_errors);
        if (compare_errors + flow_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #(PERIOD / 2) clock = ~clock;

endmodule

`default_nettype wire

/* alu_cluster.sv */
`default_nettype none

module alu_cluster import exec_pkg::*; #(
    parameter int NUM_FU = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic        [NUM_FU-1:0] issue_valid,
    input  data_t       [NUM_FU-1:0] rs1_value,
    input  data_t       [NUM_FU-1:0] rs2_value,
    input  data_t       [NUM_FU-1:0] pc,
    input  data_t       [NUM_FU-1:0] npc,
    input  data_t       [NUM_FU-1:0] inst,
    input  alu_func_t   [NUM_FU-1:0] alu_func,
    input  opa_select_t [NUM_FU-1:0] opa_select,
    input  opb_select_t [NUM_FU-1:0] opb_select,
    input  tag_t        [NUM_FU-1:0] tag,
    input  br_mask_t    [NUM_FU-1:0] b_mask,
    input  br_task_t                 rem_br_task,
    input  br_mask_t                 rem_b_id,
    output logic        [NUM_FU-1:0] alu_stall,
    output logic                     cdb_valid,
    output data_t                    cdb_result,
    output tag_t                     cdb_tag,
    output br_mask_t                 cdb_b_mask
);

    logic     [NUM_FU-1:0] fu_valid;
    data_t    [NUM_FU-1:0] fu_result;
    tag_t     [NUM_FU-1:0] fu_tag;
    br_mask_t [NUM_FU-1:0] fu_b_mask;

    for (genvar i = 0; i < NUM_FU; i++) begin : g_fu
        alu_fu u_fu (
            .clock       (clock),
            .reset       (reset),
            .issue_valid (issue_valid[i]),
            .rs1_value   (rs1_value[i]),
            .rs2_value   (rs2_value[i]),
            .pc          (pc[i]),
            .npc         (npc[i]),
            .inst        (inst[i]),
            .alu_func    (alu_func[i]),
            .opa_select  (opa_select[i]),
            .opb_select  (opb_select[i]),
            .tag         (tag[i]),
            .b_mask      (b_mask[i]),
            .stall       (alu_stall[i]),        // Arbiter back-pressure closes the loop
            .rem_br_task (rem_br_task),
            .rem_b_id    (rem_b_id),
            .fu_valid    (fu_valid[i]),
            .fu_result   (fu_result[i]),
            .fu_tag      (fu_tag[i]),
            .fu_b_mask   (fu_b_mask[i])
        );
    end

    cdb_arbiter #(
        .NUM_FU (NUM_FU)
    ) u_arbiter (
        .fu_valid   (fu_valid),
        .fu_result  (fu_result),
        .fu_tag     (fu_tag),
        .fu_b_mask  (fu_b_mask),
        .stall      (alu_stall),
        .cdb_valid  (cdb_valid),
        .cdb_result (cdb_result),
        .cdb_tag    (cdb_tag),
        .cdb_b_mask (cdb_b_mask)
    );

endmodule

`default_nettype wire

/* cdb_arbiter.sv */
`default_nettype none

module cdb_arbiter import exec_pkg::*; #(
    parameter int NUM_FU = 2
) (
    input  logic     [NUM_FU-1:0] fu_valid,
    input  data_t    [NUM_FU-1:0] fu_result,
    input  tag_t     [NUM_FU-1:0] fu_tag,
    input  br_mask_t [NUM_FU-1:0] fu_b_mask,
    output logic     [NUM_FU-1:0] stall,
    output logic                  cdb_valid,
    output data_t                 cdb_result,
    output tag_t                  cdb_tag,
    output br_mask_t              cdb_b_mask
);

    logic [NUM_FU-1:0] grant;
    logic              found;

    // Lowest index wins
    always_comb begin
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (fu_valid[i] && !found) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    // Grant is one-hot, so an OR of the gated entries is the selected one
    always_comb begin
        cdb_result = '0;
        cdb_tag    = '0;
        cdb_b_mask = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (grant[i]) begin
                cdb_result = cdb_result | fu_result[i];
                cdb_tag    = cdb_tag | fu_tag[i];
                cdb_b_mask = cdb_b_mask | fu_b_mask[i];
            end
        end
    end

    assign cdb_valid = found;
    assign stall     = fu_valid & ~grant;           // Every loser holds its entry

endmodule

`default_nettype wire

/* alu_fu.sv */
`default_nettype none

module alu_fu import exec_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  data_t       rs1_value,
    input  data_t       rs2_value,
    input  data_t       pc,
    input  data_t       npc,
    input  data_t       inst,
    input  alu_func_t   alu_func,
    input  opa_select_t opa_select,
    input  opb_select_t opb_select,
    input  tag_t        tag,
    input  br_mask_t    b_mask,
    input  logic        stall,
    input  br_task_t    rem_br_task,
    input  br_mask_t    rem_b_id,
    output logic        fu_valid,
    output data_t       fu_result,
    output tag_t        fu_tag,
    output br_mask_t    fu_b_mask
);

    data_t    opa;
    data_t    opb;
    data_t    result;
    logic     load;
    logic     entry_valid;
    data_t    entry_result;
    tag_t     entry_tag;
    br_mask_t entry_b_mask;
    logic     next_valid;
    br_mask_t next_b_mask;

    alu_operand_select u_operand_select (
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .pc         (pc),
        .npc        (npc),
        .inst       (inst),
        .opa_select (opa_select),
        .opb_select (opb_select),
        .opa        (opa),
        .opb        (opb)
    );

    alu_core u_core (
        .opa      (opa),
        .opb      (opb),
        .alu_func (alu_func),
        .result   (result)
    );

    assign load = issue_valid && !stall;            // A strobe while stalled is dropped

    // Branch resolution works on the value about to be stored, never on the
    // entry currently on the CDB
    always_comb begin
        next_valid  = stall ? entry_valid : load;
        next_b_mask = load ? b_mask : entry_b_mask;
        if (next_valid && ((next_b_mask & rem_b_id) != '0)) begin
            if (rem_br_task == BR_SQUASH) begin
                next_valid = 1'b0;
            end
            if (rem_br_task == BR_CLEAR) begin
                next_b_mask = next_b_mask & ~rem_b_id;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid  <= 1'b0;
            entry_b_mask <= '0;
        end else begin
            entry_valid  <= next_valid;
            entry_b_mask <= next_b_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            entry_result <= result;
            entry_tag    <= tag;
        end
    end

    assign fu_valid  = entry_valid;
    assign fu_result = entry_result;
    assign fu_tag    = entry_tag;
    assign fu_b_mask = entry_b_mask;

endmodule

`default_nettype wire

/* alu_operand_select.sv */
`default_nettype none

module alu_operand_select import exec_pkg::*; (
    input  data_t       rs1_value,
    input  data_t       rs2_value,
    input  data_t       pc,
    input  data_t       npc,
    input  data_t       inst,
    input  opa_select_t opa_select,
    input  opb_select_t opb_select,
    output data_t       opa,
    output data_t       opb
);

    data_t i_imm;
    data_t s_imm;
    data_t b_imm;
    data_t u_imm;
    data_t j_imm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32 immediates, all sign-extended from inst[31]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opa_select)
            OPA_IS_RS1:  opa = rs1_value;
            OPA_IS_NPC:  opa = npc;
            OPA_IS_PC:   opa = pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = OPA_BAD;
        endcase
    end

    always_comb begin
        case (opb_select)
            OPB_IS_RS2:   opb = rs2_value;
            OPB_IS_I_IMM: opb = i_imm;
            OPB_IS_S_IMM: opb = s_imm;
            OPB_IS_B_IMM: opb = b_imm;
            OPB_IS_U_IMM: opb = u_imm;
            OPB_IS_J_IMM: opb = j_imm;
            default:      opb = OPB_BAD;     // Codes 6 and 7
        endcase
    end

endmodule

`default_nettype wire

/* alu_core.sv */
`default_nettype none

module alu_core import exec_pkg::*; (
    input  data_t     opa,
    input  data_t     opb,
    input  alu_func_t alu_func,
    output data_t     result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = opb[4:0];                  // RV32 shifts use five bits only
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (alu_func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SRL:  result = opa >> shamt;
            ALU_SLL:  result = opa << shamt;
            ALU_SRA:  result = data_t'($signed(opa) >>> shamt);
            default:  result = ALU_BAD_RESULT;
        endcase
    end

endmodule

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and basic words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int BR_MASK_W = 4;    // One bit per unresolved branch
    localparam int TAG_W     = 5;

    typedef logic [31:0]          data_t;
    typedef logic [BR_MASK_W-1:0] br_mask_t;
    typedef logic [TAG_W-1:0]     tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Function and operand select codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_SLT  = 4'h3,
        ALU_SLTU = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SRL  = 4'h7,
        ALU_SLL  = 4'h8,
        ALU_SRA  = 4'h9     // Codes above this one are undefined
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_select_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_select_t;

    typedef enum logic [1:0] {
        BR_NONE   = 2'h0,
        BR_SQUASH = 2'h1,
        BR_CLEAR  = 2'h2
    } br_task_t;

    // Recognisable fill words for undefined codes
    localparam data_t ALU_BAD_RESULT = 32'hfacebeec;
    localparam data_t OPA_BAD        = 32'hdeadface;
    localparam data_t OPB_BAD        = 32'hfacefeed;

endpackage

`default_nettype wire
